// File: sources.f
hw/conv_route_pkg.sv
hw/route_win_if.sv
hw/input_buffer.sv
hw/input_controller.sv
hw/tile_reader.sv
hw/route_fifo.sv
hw/conv_route_top.sv
verification/tb_clk_gen.sv
verification/conv_route_props.sv
verification/conv_route_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = conv_route_tb
FILELIST = sources.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "Simulation passed" $(LOG) || (echo "Test FAILED"; exit 1)
	@echo "Test PASSED"

clean:
	rm -rf $(BUILD) $(LOG)

// File: verification/conv_route_tb.sv
// Convolution routing testbench
`timescale 1ns/1ps

module conv_route_tb;

    localparam int MEM_WORDS = 2**conv_route_pkg::ADDR_WIDTH;

    logic                                  clk;
    logic                                  nrst;
    logic                                  i_wr_en;
    logic [conv_route_pkg::ADDR_WIDTH-1:0] i_wr_addr;
    logic [conv_route_pkg::DATA_WIDTH-1:0] i_wr_data;
    logic [conv_route_pkg::ADDR_WIDTH-1:0] i_start_addr;
    logic [conv_route_pkg::ADDR_WIDTH-1:0] i_i_size;
    logic [conv_route_pkg::ADDR_WIDTH-1:0] i_o_size;
    logic [conv_route_pkg::ADDR_WIDTH-1:0] i_stride;
    logic [conv_route_pkg::ADDR_WIDTH-1:0] i_i_c_size;
    logic                                  i_en;
    logic                                  i_reg_clear;
    logic                                  i_pop;
    logic [conv_route_pkg::DATA_WIDTH-1:0] o_data;
    logic                                  o_valid;
    logic                                  o_ready;
    logic                                  o_context_done;
    logic                                  o_done;

    // Copy of the buffer contents for the model
    logic [conv_route_pkg::DATA_WIDTH-1:0] ref_mem [MEM_WORDS];
    logic [conv_route_pkg::DATA_WIDTH-1:0] expected [$];
    int seed = 65;
    int data_errors = 0;
    int ctrl_errors = 0;
    bit verdict_given = 1'b0;

    tb_clk_gen clk_gen_inst (
        .o_clk  (clk),
        .o_nrst (nrst)
    );

    conv_route_top conv_route_top_inst (
        .i_clk  (clk),
        .i_nrst (nrst),
        .*
    );

    bind conv_route_top conv_route_props props_inst (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_reg_clear (i_reg_clear),
        .i_pop       (i_pop),
        .i_data      (o_data),
        .i_valid     (o_valid),
        .i_ready     (o_ready),
        .i_ctx_done  (o_context_done),
        .i_done      (o_done),
        .i_route_en  (route_en),
        .i_pop_en    (pop_en)
    );

    function automatic int layer_words(input int osz, input int c);
        return osz * osz * c;
    endfunction

    task automatic load_buffer();
        logic [conv_route_pkg::DATA_WIDTH-1:0] word;
        for (int a = 0; a < MEM_WORDS; a++) begin
            word = conv_route_pkg::DATA_WIDTH'($random(seed));
            ref_mem[a] = word;
            @(posedge clk);
            i_wr_en   <= 1'b1;
            i_wr_addr <= conv_route_pkg::ADDR_WIDTH'(a);
            i_wr_data <= word;
        end
        @(posedge clk);
        i_wr_en <= 1'b0;
    endtask

    // Expected words in pop order, y inner loop
    task automatic build_model(input int base, input int isz, input int osz,
                               input int s, input int c);
        logic [conv_route_pkg::ADDR_WIDTH-1:0] addr;
        expected.delete();
        for (int x = 0; x < osz; x++) begin
            for (int y = 0; y < osz; y++) begin
                for (int k = 0; k < c; k++) begin
                    addr = conv_route_pkg::ADDR_WIDTH'(base + ((x * s) * isz + y * s) * c + k);
                    expected.push_back(ref_mem[addr]);
                end
            end
        end
    endtask

    task automatic set_layer(input int base, input int isz, input int osz,
                             input int s, input int c);
        i_start_addr <= conv_route_pkg::ADDR_WIDTH'(base);
        i_i_size     <= conv_route_pkg::ADDR_WIDTH'(isz);
        i_o_size     <= conv_route_pkg::ADDR_WIDTH'(osz);
        i_stride     <= conv_route_pkg::ADDR_WIDTH'(s);
        i_i_c_size   <= conv_route_pkg::ADDR_WIDTH'(c);
    endtask

    task automatic check_quiet(input string name);
        logic [6:0] ctl;
        ctl = {o_ready, o_valid, o_done, o_context_done, conv_route_top_inst.route_en,
               conv_route_top_inst.pop_en, conv_route_top_inst.win.write_en};
        assert (ctl == 7'b0) else begin
            $display("[ERROR] %s: expected control %b, actual %b", name, 7'b0, ctl);
            ctrl_errors++;
        end
    endtask

    task automatic run_layer(input string name, input int base, input int isz,
                             input int osz, input int s, input int c, input bit gaps);
        logic [conv_route_pkg::DATA_WIDTH-1:0] exp_word;
        int popped;
        int contexts;
        bit ctx_prev;
        bit done_seen;
        build_model(base, isz, osz, s, c);
        popped    = 0;
        contexts  = 0;
        ctx_prev  = 1'b0;
        done_seen = 1'b0;
        @(posedge clk);
        set_layer(base, isz, osz, s, c);
        i_en <= 1'b1;
        while (!done_seen) begin
            @(negedge clk);
            if (o_valid && i_pop) begin
                assert (expected.size() > 0) else begin
                    $display("%s: DUT returned more words than the layer holds", name);
                    ctrl_errors++;
                end
                if (expected.size() > 0) begin
                    exp_word = expected.pop_front();
                    assert (o_data == exp_word) else begin
                        $display("[ERROR] %s word %0d: expected %h, actual %h",
                                 name, popped, exp_word, o_data);
                        data_errors++;
                    end
                end
                popped++;
            end
            // A full context is COUNT windows of c words
            if (o_context_done && !ctx_prev) begin
                contexts++;
                assert (popped == contexts * conv_route_pkg::COUNT * c) else begin
                    $display("[ERROR] %s context %0d end: expected %0d words, actual %0d",
                             name, contexts, contexts * conv_route_pkg::COUNT * c, popped);
                    ctrl_errors++;
                end
            end
            ctx_prev  = o_context_done;
            done_seen = o_done;
            @(posedge clk);
            i_pop <= gaps ? (($random(seed) & 3) != 0) : 1'b1;
        end
        assert (popped == layer_words(osz, c)) else begin
            $display("[ERROR] %s word count: expected %0d, actual %0d",
                     name, layer_words(osz, c), popped);
            ctrl_errors++;
        end
        assert (contexts == (osz * osz - 1) / conv_route_pkg::COUNT) else begin
            $display("[ERROR] %s context count: expected %0d, actual %0d",
                     name, (osz * osz - 1) / conv_route_pkg::COUNT, contexts);
            ctrl_errors++;
        end
        i_en        <= 1'b0;
        i_pop       <= 1'b0;
        i_reg_clear <= 1'b1;
        @(posedge clk);
        i_reg_clear <= 1'b0;
    endtask

    initial begin
        i_wr_en      = 1'b0;
        i_wr_addr    = '0;
        i_wr_data    = '0;
        i_start_addr = '0;
        i_i_size     = '0;
        i_o_size     = '0;
        i_stride     = '0;
        i_i_c_size   = '0;
        i_en         = 1'b0;
        i_reg_clear  = 1'b0;
        i_pop        = 1'b0;
        wait (nrst);
        @(negedge clk);
        check_quiet("reset");
        load_buffer();

        // Host clear while a context waits in the FIFO
        @(posedge clk);
        set_layer(0, 3, 3, 1, 4);
        i_en <= 1'b1;
        @(negedge clk);
        while (!o_valid) begin
            @(negedge clk);
        end
        @(posedge clk);
        i_reg_clear <= 1'b1;
        i_en        <= 1'b0;
        @(posedge clk);
        i_reg_clear <= 1'b0;
        @(negedge clk);
        check_quiet("mid_run_clear");

        run_layer("pointwise", 0, 3, 3, 1, 4, 1'b0);
        run_layer("stride_base", 40, 5, 3, 2, 2, 1'b0);
        run_layer("backpressure", 0, 3, 3, 1, 4, 1'b1);
        run_layer("channel_limit", 0, 4, 4, 1, conv_route_pkg::MAX_CH, 1'b0);

        verdict_given = 1'b1;
        $display("Errors: %0d data, %0d control", data_errors, ctrl_errors);
        if (data_errors + ctrl_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Budget of 20 cycles per word over every test, plus the buffer load
    initial begin
        int limit_cycles;
        limit_cycles = MEM_WORDS + 500 + 20 * (3 * layer_words(3, 4) + layer_words(3, 2)
                       + layer_words(4, conv_route_pkg::MAX_CH));
        repeat (limit_cycles) @(posedge clk);
        verdict_given = 1'b1;
        $display("Watchdog expired after %0d cycles, the DUT stopped responding", limit_cycles);
        $display("Simulation failed");
        $finish;
    end

    // Run stopped early by a failed bound assertion
    final begin
        if (!verdict_given) begin
            $display("Run stopped before the test sequence finished");
            $display("Simulation failed");
        end
    end

endmodule

// File: verification/conv_route_props.sv
// Top-level protocol assertions
`timescale 1ns/1ps

module conv_route_props (
    input logic                                  i_clk,
    input logic                                  i_nrst,
    input logic                                  i_reg_clear,
    input logic                                  i_pop,
    input logic [conv_route_pkg::DATA_WIDTH-1:0] i_data,
    input logic                                  i_valid,
    input logic                                  i_ready,
    input logic                                  i_ctx_done,
    input logic                                  i_done,
    input logic                                  i_route_en,
    input logic                                  i_pop_en
);

    // Drained FIFO closes the context on the next edge
    ready_falls_when_drained: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (i_ready && !i_valid) |=> !i_ready)
        else $error("o_ready still high a cycle after the FIFO drained");

    done_exclusive: assert property (@(posedge i_clk) disable iff (!i_nrst)
        !(i_done && i_ctx_done))
        else $error("o_done and o_context_done high together");

    // Every control output drops one cycle after a host clear
    clear_quiets: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_reg_clear |=> !(i_ready || i_valid || i_done || i_ctx_done
                          || i_route_en || i_pop_en))
        else $error("Control output still high after i_reg_clear");

    // Head word waits for the host
    head_stable: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (i_valid && !i_pop && !i_reg_clear) |=> $stable(i_data))
        else $error("o_data changed while o_valid was high and i_pop low");

endmodule

// File: verification/tb_clk_gen.sv
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clk_gen (
    output logic o_clk,
    output logic o_nrst
);

    // 20 ns period
    initial begin
        o_clk = 1'b0;
        forever #10 o_clk = ~o_clk;
    end

    // Reset held for three cycles
    initial begin
        o_nrst = 1'b0;
        repeat (3) @(posedge o_clk);
        o_nrst <= 1'b1;
    end

endmodule

// File: hw/conv_route_top.sv
// Convolution input routing top
`timescale 1ns/1ps

module conv_route_top (
    input  logic                                  i_clk,
    input  logic                                  i_nrst,

    input  logic                                  i_wr_en,
    input  logic [conv_route_pkg::ADDR_WIDTH-1:0] i_wr_addr,
    input  logic [conv_route_pkg::DATA_WIDTH-1:0] i_wr_data,

    input  logic [conv_route_pkg::ADDR_WIDTH-1:0] i_start_addr,
    input  logic [conv_route_pkg::ADDR_WIDTH-1:0] i_i_size,
    input  logic [conv_route_pkg::ADDR_WIDTH-1:0] i_o_size,
    input  logic [conv_route_pkg::ADDR_WIDTH-1:0] i_stride,
    input  logic [conv_route_pkg::ADDR_WIDTH-1:0] i_i_c_size,

    input  logic                                  i_en,
    input  logic                                  i_reg_clear,
    input  logic                                  i_pop,
    output logic [conv_route_pkg::DATA_WIDTH-1:0] o_data,
    output logic                                  o_valid,
    output logic                                  o_ready,
    output logic                                  o_context_done,
    output logic                                  o_done
);

    logic [conv_route_pkg::ADDR_WIDTH-1:0] rd_addr;
    logic [conv_route_pkg::DATA_WIDTH-1:0] rd_data;
    logic [conv_route_pkg::DATA_WIDTH-1:0] push_data;
    logic                                  push;
    logic                                  route_en;
    logic                                  pop_en;
    logic                                  ctrl_clear;
    logic                                  clear_all;
    logic                                  fifo_pop_ready;
    logic                                  fifo_empty;

    route_win_if win ();

    // Host clear also flushes the reader and FIFO
    assign clear_all = ctrl_clear | i_reg_clear;
    assign o_valid   = o_ready & ~fifo_empty;

    input_buffer input_buffer_inst (
        .i_clk     (i_clk),
        .i_wr_en   (i_wr_en),
        .i_wr_addr (i_wr_addr),
        .i_wr_data (i_wr_data),
        .i_rd_addr (rd_addr),
        .o_rd_data (rd_data)
    );

    input_controller input_controller_inst (
        .i_clk            (i_clk),
        .i_nrst           (i_nrst),
        .i_en             (i_en),
        .i_reg_clear      (i_reg_clear),
        .i_start_addr     (i_start_addr),
        .i_i_size         (i_i_size),
        .i_o_size         (i_o_size),
        .i_stride         (i_stride),
        .i_i_c_size       (i_i_c_size),
        .i_fifo_pop_ready (fifo_pop_ready),
        .i_fifo_empty     (fifo_empty),
        .win              (win.ctrl),
        .o_route_en       (route_en),
        .o_pop_en         (pop_en),
        .o_reg_clear      (ctrl_clear),
        .o_ready          (o_ready),
        .o_context_done   (o_context_done),
        .o_done           (o_done)
    );

    tile_reader tile_reader_inst (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .win         (win.reader),
        .i_route_en  (route_en),
        .i_reg_clear (clear_all),
        .o_rd_addr   (rd_addr),
        .i_rd_data   (rd_data),
        .o_push      (push),
        .o_push_data (push_data),
        .o_pop_ready (fifo_pop_ready)
    );

    route_fifo route_fifo_inst (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_clear     (clear_all),
        .i_push      (push),
        .i_push_data (push_data),
        .i_pop_en    (pop_en),
        .i_pop       (i_pop),
        .o_head      (o_data),
        .o_empty     (fifo_empty)
    );

endmodule

// File: hw/route_fifo.sv
// Routed word FIFO
`timescale 1ns/1ps

module route_fifo (
    input  logic                                  i_clk,
    input  logic                                  i_nrst,
    input  logic                                  i_clear,
    input  logic                                  i_push,
    input  logic [conv_route_pkg::DATA_WIDTH-1:0] i_push_data,
    input  logic                                  i_pop_en,
    input  logic                                  i_pop,
    output logic [conv_route_pkg::DATA_WIDTH-1:0] o_head,
    output logic                                  o_empty
);

    logic [conv_route_pkg::DATA_WIDTH-1:0]          mem [conv_route_pkg::FIFO_DEPTH];
    logic [$clog2(conv_route_pkg::FIFO_DEPTH)-1:0]  wr_ptr;
    logic [$clog2(conv_route_pkg::FIFO_DEPTH)-1:0]  rd_ptr;
    logic [$clog2(conv_route_pkg::FIFO_DEPTH):0]    count;
    logic                                           do_push;
    logic                                           do_pop;

    assign o_empty = (count == '0);
    assign o_head  = mem[rd_ptr];
    assign do_pop  = i_pop_en && i_pop && !o_empty;
    assign do_push = i_push && (count != conv_route_pkg::FIFO_DEPTH);

    always_ff @(posedge i_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_push_data;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (i_clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Depth is a power of two, pointers wrap naturally
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + do_push - do_pop;
        end
    end

endmodule

// File: hw/tile_reader.sv
// Slot window reader
`timescale 1ns/1ps

module tile_reader (
    input  logic                                  i_clk,
    input  logic                                  i_nrst,
    route_win_if.reader                           win,
    input  logic                                  i_route_en,
    input  logic                                  i_reg_clear,
    output logic [conv_route_pkg::ADDR_WIDTH-1:0] o_rd_addr,
    input  logic [conv_route_pkg::DATA_WIDTH-1:0] i_rd_data,
    output logic                                  o_push,
    output logic [conv_route_pkg::DATA_WIDTH-1:0] o_push_data,
    output logic                                  o_pop_ready
);

    conv_route_pkg::reader_state_e state;

    logic [conv_route_pkg::ADDR_WIDTH-1:0] slot_start [conv_route_pkg::COUNT];
    logic [conv_route_pkg::ADDR_WIDTH-1:0] slot_end   [conv_route_pkg::COUNT];
    logic [conv_route_pkg::ID_WIDTH-1:0]   cur_slot;
    logic [conv_route_pkg::ID_WIDTH:0]     next_cnt;
    logic [conv_route_pkg::ADDR_WIDTH-1:0] rd_addr;
    logic [conv_route_pkg::ADDR_WIDTH-1:0] next_addr;
    logic                                  push_q;

    assign next_cnt    = {1'b0, cur_slot} + 1'b1;
    assign next_addr   = rd_addr + 1'b1;
    assign o_rd_addr   = rd_addr;
    assign o_push      = push_q;
    assign o_push_data = i_rd_data;

    always_ff @(posedge i_clk) begin
        if (i_reg_clear) begin
            for (int i = 0; i < conv_route_pkg::COUNT; i++) begin
                slot_start[i] <= '0;
                slot_end[i]   <= '0;
            end
        end else if (win.write_en) begin
            slot_start[win.id] <= win.start_addr;
            slot_end[win.id]   <= win.end_addr;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state       <= conv_route_pkg::R_IDLE;
            cur_slot    <= '0;
            rd_addr     <= '0;
            push_q      <= 1'b0;
            o_pop_ready <= 1'b0;
        end else if (i_reg_clear) begin
            state       <= conv_route_pkg::R_IDLE;
            cur_slot    <= '0;
            rd_addr     <= '0;
            push_q      <= 1'b0;
            o_pop_ready <= 1'b0;
        end else begin
            // Buffer data returns one cycle after the address
            push_q <= (state == conv_route_pkg::R_READ);
            case (state)
                conv_route_pkg::R_IDLE: begin
                    if (i_route_en) begin
                        cur_slot <= '0;
                        rd_addr  <= slot_start[0];
                        state    <= conv_route_pkg::R_READ;
                    end
                end
                conv_route_pkg::R_READ: begin
                    if (next_addr != slot_end[cur_slot]) begin
                        rd_addr <= next_addr;
                    end else if (next_cnt == win.slot_count) begin
                        state <= conv_route_pkg::R_DONE;
                    end else begin
                        cur_slot <= cur_slot + 1'b1;
                        rd_addr  <= slot_start[cur_slot + 1'b1];
                    end
                end
                conv_route_pkg::R_DONE: begin
                    // Last push lands on this edge
                    o_pop_ready <= 1'b1;
                end
                default: begin
                    state <= conv_route_pkg::R_IDLE;
                end
            endcase
        end
    end

endmodule

// File: hw/input_controller.sv
// Pixel walk and context control
`timescale 1ns/1ps

module input_controller (
    input  logic                                  i_clk,
    input  logic                                  i_nrst,
    input  logic                                  i_en,
    input  logic                                  i_reg_clear,

    input  logic [conv_route_pkg::ADDR_WIDTH-1:0] i_start_addr,
    input  logic [conv_route_pkg::ADDR_WIDTH-1:0] i_i_size,
    input  logic [conv_route_pkg::ADDR_WIDTH-1:0] i_o_size,
    input  logic [conv_route_pkg::ADDR_WIDTH-1:0] i_stride,
    input  logic [conv_route_pkg::ADDR_WIDTH-1:0] i_i_c_size,

    input  logic                                  i_fifo_pop_ready,
    input  logic                                  i_fifo_empty,
    route_win_if.ctrl                             win,

    output logic                                  o_route_en,
    output logic                                  o_pop_en,
    output logic                                  o_reg_clear,
    output logic                                  o_ready,
    output logic                                  o_context_done,
    output logic                                  o_done
);

    conv_route_pkg::ctrl_state_e state;

    logic [conv_route_pkg::ADDR_WIDTH-1:0] x_pos;
    logic [conv_route_pkg::ADDR_WIDTH-1:0] y_pos;
    logic [conv_route_pkg::ADDR_WIDTH-1:0] pix_start;
    logic [conv_route_pkg::ID_WIDTH-1:0]   slot_id;
    logic [conv_route_pkg::ADDR_WIDTH-1:0] win_start;
    logic [conv_route_pkg::ADDR_WIDTH-1:0] win_end;
    logic [conv_route_pkg::ID_WIDTH:0]     slot_count;
    logic                                  win_write;
    logic                                  xy_done;
    logic                                  x_last;
    logic                                  y_last;

    assign x_last = (x_pos == i_o_size - 1'b1);
    assign y_last = (y_pos == i_o_size - 1'b1);

    // Input pixel (x*stride, y*stride), c words per pixel
    assign pix_start = i_start_addr
                     + ((x_pos * i_stride) * i_i_size + y_pos * i_stride) * i_i_c_size;

    assign win.id         = slot_id;
    assign win.start_addr = win_start;
    assign win.end_addr   = win_end;
    assign win.write_en   = win_write;
    assign win.slot_count = slot_count;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state          <= conv_route_pkg::IDLE;
            x_pos          <= '0;
            y_pos          <= '0;
            slot_id        <= '0;
            win_start      <= '0;
            win_end        <= '0;
            slot_count     <= '0;
            win_write      <= 1'b0;
            xy_done        <= 1'b0;
            o_route_en     <= 1'b0;
            o_pop_en       <= 1'b0;
            o_reg_clear    <= 1'b0;
            o_ready        <= 1'b0;
            o_context_done <= 1'b0;
            o_done         <= 1'b0;
        end else if (i_reg_clear) begin
            state          <= conv_route_pkg::IDLE;
            x_pos          <= '0;
            y_pos          <= '0;
            slot_id        <= '0;
            win_start      <= '0;
            win_end        <= '0;
            slot_count     <= '0;
            win_write      <= 1'b0;
            xy_done        <= 1'b0;
            o_route_en     <= 1'b0;
            o_pop_en       <= 1'b0;
            o_reg_clear    <= 1'b0;
            o_ready        <= 1'b0;
            o_context_done <= 1'b0;
            o_done         <= 1'b0;
        end else begin
            // Clear pulse lasts one cycle
            o_reg_clear <= 1'b0;
            case (state)
                conv_route_pkg::IDLE: begin
                    if (i_en && !o_done) begin
                        state <= conv_route_pkg::INIT;
                    end
                end
                conv_route_pkg::INIT: begin
                    o_context_done <= 1'b0;
                    o_ready        <= 1'b0;
                    state          <= conv_route_pkg::ADDR_WRITE;
                end
                conv_route_pkg::ADDR_WRITE: begin
                    win_start  <= pix_start;
                    win_end    <= pix_start + i_i_c_size;
                    slot_count <= {1'b0, slot_id} + 1'b1;
                    win_write  <= 1'b1;
                    state      <= conv_route_pkg::XY_INCREMENT;
                end
                conv_route_pkg::XY_INCREMENT: begin
                    win_write <= 1'b0;
                    // y is the inner loop
                    if (!y_last) begin
                        y_pos <= y_pos + 1'b1;
                    end else if (!x_last) begin
                        y_pos <= '0;
                        x_pos <= x_pos + 1'b1;
                    end else begin
                        y_pos   <= '0;
                        x_pos   <= '0;
                        xy_done <= 1'b1;
                    end
                    if ((x_last && y_last) || slot_id == conv_route_pkg::ID_WIDTH'(
                            conv_route_pkg::COUNT - 1)) begin
                        slot_id <= '0;
                        state   <= conv_route_pkg::WRITE_STALL;
                    end else begin
                        slot_id <= slot_id + 1'b1;
                        state   <= conv_route_pkg::ADDR_WRITE;
                    end
                end
                conv_route_pkg::WRITE_STALL: begin
                    state <= conv_route_pkg::TILE_COMPARISON;
                end
                conv_route_pkg::TILE_COMPARISON: begin
                    if (i_fifo_pop_ready) begin
                        o_route_en <= 1'b0;
                        o_ready    <= 1'b1;
                        o_pop_en   <= 1'b1;
                        state      <= conv_route_pkg::DATA_OUT;
                    end else begin
                        o_route_en <= 1'b1;
                    end
                end
                conv_route_pkg::DATA_OUT: begin
                    // Host drains the FIFO, then the context closes
                    if (i_fifo_empty) begin
                        o_pop_en    <= 1'b0;
                        o_ready     <= 1'b0;
                        o_reg_clear <= 1'b1;
                        if (xy_done) begin
                            o_done <= 1'b1;
                        end else begin
                            o_context_done <= 1'b1;
                        end
                        state <= conv_route_pkg::IDLE;
                    end
                end
                default: begin
                    state <= conv_route_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

// File: hw/input_buffer.sv
// Input feature map memory
`timescale 1ns/1ps

module input_buffer (
    input  logic                                  i_clk,
    input  logic                                  i_wr_en,
    input  logic [conv_route_pkg::ADDR_WIDTH-1:0] i_wr_addr,
    input  logic [conv_route_pkg::DATA_WIDTH-1:0] i_wr_data,
    input  logic [conv_route_pkg::ADDR_WIDTH-1:0] i_rd_addr,
    output logic [conv_route_pkg::DATA_WIDTH-1:0] o_rd_data
);

    // NHWC words, one per address
    logic [conv_route_pkg::DATA_WIDTH-1:0] mem [2**conv_route_pkg::ADDR_WIDTH];

    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    // Registered read, one cycle of latency
    always_ff @(posedge i_clk) begin
        o_rd_data <= mem[i_rd_addr];
    end

endmodule

// File: hw/route_win_if.sv
// Slot window write channel
`timescale 1ns/1ps

interface route_win_if;

    logic [conv_route_pkg::ID_WIDTH-1:0]   id;
    logic [conv_route_pkg::ADDR_WIDTH-1:0] start_addr;
    logic [conv_route_pkg::ADDR_WIDTH-1:0] end_addr;
    logic                                  write_en;
    // Valid slots in the current context, 1 to COUNT
    logic [conv_route_pkg::ID_WIDTH:0]     slot_count;

    modport ctrl (
        output id,
        output start_addr,
        output end_addr,
        output write_en,
        output slot_count
    );

    modport reader (
        input id,
        input start_addr,
        input end_addr,
        input write_en,
        input slot_count
    );

endinterface

// File: hw/conv_route_pkg.sv
// Convolution routing definitions
package conv_route_pkg;

    // Reader slots, one pixel per slot
    localparam int COUNT = 4;
    localparam int ADDR_WIDTH = 8;
    localparam int DATA_WIDTH = 16;
    localparam int MAX_CH = 8;

    // One full context always fits
    localparam int FIFO_DEPTH = COUNT * MAX_CH;
    localparam int ID_WIDTH = 2;

    typedef enum logic [2:0] {
        IDLE,
        INIT,
        ADDR_WRITE,
        XY_INCREMENT,
        WRITE_STALL,
        TILE_COMPARISON,
        DATA_OUT
    } ctrl_state_e;

    typedef enum logic [1:0] {
        R_IDLE,
        R_READ,
        R_DONE
    } reader_state_e;

endpackage
